// ==== files.f ====
rtl/kd_tree_pkg.sv
rtl/traverse_if.sv
rtl/internal_node.sv
rtl/kd_tree_level.sv
rtl/leaf_credit_buffer.sv
rtl/kd_tree_top.sv
dv/kd_tree_asserts.sv
dv/kd_tree_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the KD-tree testbench with Verilator, pass only on the pass message

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module kd_tree_tb \
    -f files.f -o kd_tree_sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/kd_tree_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1

// ==== dv/kd_tree_tb.sv ====
/* Testbench for the KD-tree search engine with LCG stimulus and a software tree model.
   Results are scoreboarded in order; credit and latency rules sit in the bound asserts. */

`timescale 1ns/10ps

module kd_tree_tb;
  import kd_tree_pkg::*;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 16;
  localparam int num_random   = 64;
  localparam int num_latency  = 4;
  localparam int num_directed = 4;
  localparam int num_requests = buf_depth + num_random + num_latency + num_directed;
  localparam int watchdog_ns  = (num_requests + 100) * clk_period * 4;

  logic                       clk;
  logic                       rst_n;
  logic                       in_valid;
  logic                       in_valid_a;
  logic                       in_valid_b;
  patch_t                     patch_a;
  patch_t                     patch_b;
  logic                       in_credit;
  logic                       cfg_wen;
  logic [node_addr_width-1:0] cfg_waddr;
  logic [cfg_width-1:0]       cfg_wdata;
  logic [node_addr_width-1:0] cfg_raddr;
  logic [cfg_width-1:0]       cfg_rdata;
  logic                       out_credit;
  logic                       out_valid;
  leaf_result_t               out_result;

  int                            model_dim [num_nodes]; // Software copy of the tree
  logic signed [coord_width-1:0] model_med [num_nodes];
  leaf_result_t                  exp_q [$];        // Results expected, oldest first
  int unsigned                   lcg_state = 15;
  int                            up_credits;       // Upstream view of free entries
  int                            credit_owed;      // Slots downstream still has to grant
  logic                          hold_credit;      // Downstream withholds grants
  int                            value_errs;
  int                            other_errs;
  int                            checked;

  kd_tree_top DUT (
    .clk (clk), .rst_n (rst_n),
    .in_valid (in_valid), .in_valid_a (in_valid_a), .in_valid_b (in_valid_b),
    .patch_a (patch_a), .patch_b (patch_b), .in_credit (in_credit),
    .cfg_wen (cfg_wen), .cfg_waddr (cfg_waddr), .cfg_wdata (cfg_wdata),
    .cfg_raddr (cfg_raddr), .cfg_rdata (cfg_rdata),
    .out_credit (out_credit), .out_valid (out_valid), .out_result (out_result)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [coord_width-1:0] random_coord();
    int unsigned r;
    r = lcg_next();
    return r[26:16]; // Upper bits mix best
  endfunction

  function automatic patch_t random_patch();
    patch_t p;
    for (int k = 0; k < num_dims; k++) p[k*coord_width +: coord_width] = random_coord();
    return p;
  endfunction

  // Coordinate 0 lands in the LSBs
  function automatic patch_t make_patch(input int c0, input int c1, input int c2,
                                        input int c3, input int c4);
    return {coord_width'(c4), coord_width'(c3), coord_width'(c2),
            coord_width'(c1), coord_width'(c0)};
  endfunction

  // Reference walk: right when coordinate >= median, first turn ends up in the MSB
  function automatic logic [leaf_width-1:0] walk_tree(input patch_t p);
    int                            node;
    logic [leaf_width-1:0]         path;
    logic signed [coord_width-1:0] c;
    logic                          right;
    node = 0;
    path = '0;
    for (int lvl = 0; lvl < tree_depth; lvl++) begin
      c = (model_dim[node] < num_dims) ? p[model_dim[node]*coord_width +: coord_width] : '0;
      right = (c >= model_med[node]);
      path  = {path[leaf_width-2:0], right};
      node  = 2 * node + 1 + int'(right); // Heap child
    end
    return path;
  endfunction

  task automatic write_node(input int addr, input int dim, input logic [coord_width-1:0] med);
    @(posedge clk);
    cfg_wen   <= 1'b1;
    cfg_waddr <= node_addr_width'(addr);
    cfg_wdata <= {med, 8'h00, dim_width'(dim)}; // Median, 8 zero bits, dimension
    model_dim[addr] = dim;
    model_med[addr] = med;
    @(posedge clk);
    cfg_wen <= 1'b0;
  endtask

  task automatic check_node(input int addr, input logic [cfg_width-1:0] expected);
    @(posedge clk);
    cfg_raddr <= node_addr_width'(addr);
    @(negedge clk); // Readback is combinational, settled by now
    assert (cfg_rdata == expected) else begin
      value_errs++;
      $display("FAIL cfg_rdata node %0d: got 0x%h expected 0x%h", addr, cfg_rdata, expected);
    end
  endtask

  task automatic send_request(input logic va, input logic vb, input patch_t pa, input patch_t pb);
    leaf_result_t want;
    @(posedge clk);
    while (up_credits == 0) begin // Out of credit, stay idle
      in_valid <= 1'b0;
      @(posedge clk);
    end
    in_valid   <= 1'b1;
    in_valid_a <= va;
    in_valid_b <= vb;
    patch_a    <= pa;
    patch_b    <= pb;
    up_credits--;
    want.leaf_a = va ? walk_tree(pa) : '0;
    want.leaf_b = vb ? walk_tree(pb) : '0;
    want.hit_a  = va;
    want.hit_b  = vb;
    exp_q.push_back(want);
  endtask

  task automatic send_random();
    int lanes;
    lanes = 1 + int'(lcg_next() % 3); // At least one lane
    send_request(lanes[0], lanes[1], random_patch(), random_patch());
  endtask

  task automatic go_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      in_valid   <= 1'b0;
      in_valid_a <= 1'b0;
      in_valid_b <= 1'b0;
    end
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  // Leaf only matters on a lane that carried a patch
  task automatic check_result(input leaf_result_t got);
    leaf_result_t want;
    if (exp_q.size() == 0) begin
      other_errs++;
      $display("A result came out with no request outstanding");
    end else begin
      want = exp_q.pop_front();
      checked++;
      assert (got.hit_a == want.hit_a && got.hit_b == want.hit_b) else begin
        value_errs++;
        $display("FAIL out_result.hit: got 0x%h expected 0x%h",
                 {got.hit_a, got.hit_b}, {want.hit_a, want.hit_b});
      end
      assert (!want.hit_a || got.leaf_a == want.leaf_a) else begin
        value_errs++;
        $display("FAIL out_result.leaf_a: got 0x%h expected 0x%h", got.leaf_a, want.leaf_a);
      end
      assert (!want.hit_b || got.leaf_b == want.leaf_b) else begin
        value_errs++;
        $display("FAIL out_result.leaf_b: got 0x%h expected 0x%h", got.leaf_b, want.leaf_b);
      end
    end
  endtask

  // Downstream grants one slot per cycle while it owes any
  always @(posedge clk) begin
    if (!rst_n || hold_credit || credit_owed == 0) begin
      out_credit <= 1'b0;
    end else begin
      out_credit <= 1'b1;
      credit_owed--;
    end
  end

  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      check_result(out_result);
      credit_owed++; // Slot consumed, hand it back
    end
    if (rst_n && in_credit) up_credits++;
    if (rst_n && hold_credit) begin
      assert (!out_valid) else begin
        other_errs++;
        $display("A result was sent while downstream withheld credit");
      end
    end
  end

  initial begin
    #watchdog_ns;
    $display("Timeout after %0d ns, results still outstanding: %0d", watchdog_ns, exp_q.size());
    $display("Errors: %0d value, %0d other, %0d results checked", value_errs, other_errs, checked);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_valid_a = 1'b0;
    in_valid_b = 1'b0;
    patch_a = '0;
    patch_b = '0;
    cfg_wen = 1'b0;
    cfg_waddr = '0;
    cfg_wdata = '0;
    cfg_raddr = '0;
    out_credit = 1'b0;
    hold_credit = 1'b1;
    credit_owed = buf_depth;
    up_credits = buf_depth;
    value_errs = 0;
    other_errs = 0;
    checked = 0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;

    // Unloaded nodes read dimension 7, median 0
    @(negedge clk);
    assert (!out_valid && !in_credit) else begin
      other_errs++;
      $display("out_valid or in_credit high right after reset");
    end
    for (int a = 0; a < num_nodes; a++) check_node(a, cfg_width'(7));

    for (int a = 0; a < num_nodes; a++) write_node(a, int'(lcg_next() % num_dims), random_coord());
    for (int a = 0; a < num_nodes; a++) check_node(a, {model_med[a], 8'h00, dim_width'(model_dim[a])});

    // Back-pressure, upstream runs dry after buf_depth requests
    repeat (buf_depth) send_random();
    go_idle(20);
    assert (up_credits == 0) else begin
      other_errs++;
      $display("Upstream credit did not run out while results were held");
    end
    @(negedge clk);
    hold_credit = 1'b0;
    drain();
    go_idle(4);
    assert (up_credits == buf_depth) else begin
      other_errs++;
      $display("Upstream credits not fully returned after the buffer drained");
    end

    repeat (num_random) send_random(); // Back to back
    go_idle(1);
    drain();

    // Isolated requests for the latency check
    repeat (num_latency) begin
      send_random();
      go_idle(1);
      drain();
    end

    // Ties and signed medians
    write_node(0, 0, coord_width'(-5));
    write_node(1, 1, coord_width'(0));
    write_node(2, 2, coord_width'(-300));
    write_node(3, 3, coord_width'(7));
    write_node(4, 4, coord_width'(-1));
    write_node(5, 0, coord_width'(1000));
    write_node(6, 1, coord_width'(-1024));
    send_request(1'b1, 1'b1, make_patch(-5, -1024, -300, 0, 0), make_patch(-6, 0, 0, 0, -1));
    send_request(1'b1, 1'b1, make_patch(500, 5, -200, 0, 0), make_patch(-1024, -1, 0, -7, 0));
    send_request(1'b0, 1'b1, make_patch(-5, 0, 0, 0, 0), make_patch(-5, -1024, -300, 0, 0));
    send_request(1'b1, 1'b0, make_patch(-6, 0, 0, 0, -1), make_patch(0, 0, 0, 0, 0));
    go_idle(1);
    drain();
    go_idle(4);

    assert (checked == num_requests) else begin
      other_errs++;
      $display("Only %0d of %0d results came out", checked, num_requests);
    end
    $display("Errors: %0d value, %0d other, %0d results checked", value_errs, other_errs, checked);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== dv/kd_tree_asserts.sv ====
/* Concurrent checks on reset, credit and latency rules of the KD-tree engine.
   Bound into kd_tree_top and fed only from its ports. */

`timescale 1ns/10ps

module kd_tree_asserts (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic in_valid_a,
  input logic in_valid_b,
  input logic in_credit,
  input logic out_credit,
  input logic out_valid
);
  import kd_tree_pkg::*;

  int   up_credits;  // Credits upstream still holds
  int   bank;        // Downstream grants not yet used
  int   outstanding; // Accepted requests still without a result
  logic accept;      // Request that writes the buffer

  assign accept = in_valid && (in_valid_a || in_valid_b);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      up_credits  <= buf_depth;
      bank        <= 0;
      outstanding <= 0;
    end else begin
      up_credits  <= up_credits + int'(in_credit) - int'(in_valid);
      bank        <= bank + int'(out_credit) - int'(out_valid);
      outstanding <= outstanding + int'(accept) - int'(out_valid);
    end
  end

  a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid && !in_credit)
    else $error("out_valid or in_credit high after a reset cycle");

  a_upstream_credit: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> up_credits > 0)
    else $error("Request sent without upstream credit");

  a_send_credit: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> bank > 0)
    else $error("Result sent without downstream credit");

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= buf_depth)
    else $error("More results held than the buffer has entries");

  // Result registered four edges after acceptance, seen on the fifth sample
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    accept && outstanding == 0 && bank > 0 |-> ##5 out_valid)
    else $error("Result of an isolated request missed its slot");

endmodule

bind kd_tree_top kd_tree_asserts u_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .in_valid   (in_valid),
  .in_valid_a (in_valid_a),
  .in_valid_b (in_valid_b),
  .in_credit  (in_credit),
  .out_credit (out_credit),
  .out_valid  (out_valid)
);

// ==== rtl/kd_tree_top.sv ====
/* Top of the pipelined KD-tree search engine with config and credit ports.
   Chains the tree levels through link interfaces and ends in the result buffer. */

`timescale 1ns/10ps

module kd_tree_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // Request side, one credit per in_valid cycle
  input  logic                                  in_valid,   // Request carries one or both lanes
  input  logic                                  in_valid_a,
  input  logic                                  in_valid_b,
  input  kd_tree_pkg::patch_t                   patch_a,
  input  kd_tree_pkg::patch_t                   patch_b,
  output logic                                  in_credit,
  // Node configuration
  input  logic                                  cfg_wen,
  input  logic [kd_tree_pkg::node_addr_width-1:0] cfg_waddr,
  input  logic [kd_tree_pkg::cfg_width-1:0]     cfg_wdata,
  input  logic [kd_tree_pkg::node_addr_width-1:0] cfg_raddr,
  output logic [kd_tree_pkg::cfg_width-1:0]     cfg_rdata,  // Combinational readback
  // Result side
  input  logic                                  out_credit,
  output logic                                  out_valid,
  output kd_tree_pkg::leaf_result_t             out_result
);
  import kd_tree_pkg::*;

  logic [cfg_width-1:0] node_words [num_nodes]; // Readback, heap order
  leaf_result_t         wr_result;
  logic                 wr_valid;

  traverse_if link [tree_depth+1] (); // link[0] feeds the root, last one the buffer

  // Root input, paths start empty
  assign link[0].patch_a = patch_a;
  assign link[0].patch_b = patch_b;
  assign link[0].valid_a = in_valid && in_valid_a;
  assign link[0].valid_b = in_valid && in_valid_b;
  assign link[0].path_a  = '0;
  assign link[0].path_b  = '0;

  for (genvar g = 0; g < tree_depth; g++) begin : gen_level
    logic [(1 << g)-1:0][cfg_width-1:0] rdata_lvl; // This level's node words

    kd_tree_level #(
      .level (g)
    ) u_level (
      .clk        (clk),
      .rst_n      (rst_n),
      .cfg_wen    (cfg_wen),
      .cfg_waddr  (cfg_waddr),
      .cfg_wdata  (cfg_wdata),
      .up         (link[g]),
      .down       (link[g+1]),
      .node_rdata (rdata_lvl)
    );

    // Level g starts at heap address 2^g - 1
    for (genvar i = 0; i < (1 << g); i++) begin : gen_word
      assign node_words[(1 << g) - 1 + i] = rdata_lvl[i];
    end
  end

  // Address 7 has no node behind it
  assign cfg_rdata = (cfg_raddr < node_addr_width'(num_nodes)) ? node_words[cfg_raddr] : '0;

  // Full path is the leaf number
  assign wr_result.leaf_a = link[tree_depth].path_a;
  assign wr_result.leaf_b = link[tree_depth].path_b;
  assign wr_result.hit_a  = link[tree_depth].valid_a;
  assign wr_result.hit_b  = link[tree_depth].valid_b;
  assign wr_valid         = link[tree_depth].valid_a || link[tree_depth].valid_b;

  leaf_credit_buffer u_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid   (wr_valid),
    .wr_result  (wr_result),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .in_credit  (in_credit)
  );

endmodule

// ==== rtl/leaf_credit_buffer.sv ====
/* Result FIFO between the last tree level and downstream.
   Sends only against downstream credit and returns one input credit per pop. */

`timescale 1ns/10ps

module leaf_credit_buffer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wr_valid,   // Result from the last level
  input  kd_tree_pkg::leaf_result_t wr_result,
  input  logic                      out_credit, // One slot granted by downstream
  output logic                      out_valid,
  output kd_tree_pkg::leaf_result_t out_result,
  output logic                      in_credit   // One entry freed for upstream
);
  import kd_tree_pkg::*;

  localparam int ptr_width = $clog2(buf_depth);

  leaf_result_t            mem [buf_depth]; // Circular storage
  logic [ptr_width-1:0]    wr_ptr;
  logic [ptr_width-1:0]    rd_ptr;
  logic [credit_width-1:0] count;       // Entries held
  logic [credit_width-1:0] out_credits; // Slots downstream has granted
  logic                    send;

  // Pop when something is stored and downstream has room
  // No bypass, so a write is visible one edge later at the earliest
  assign send = (count != '0) && (out_credits != '0);

  // Storage and output data
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_result; // Upstream credits keep this from overrunning
    end
    if (send) begin
      out_result <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      out_credits <= '0; // Downstream grants every slot explicitly
      out_valid   <= 1'b0;
    end else begin
      if (wr_valid) wr_ptr <= wr_ptr + 1'b1; // Wraps at buf_depth
      if (send)     rd_ptr <= rd_ptr + 1'b1;

      // Fill level
      case ({wr_valid, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase

      // Grant in, send out
      case ({out_credit, send})
        2'b10:   out_credits <= out_credits + 1'b1;
        2'b01:   out_credits <= out_credits - 1'b1;
        default: out_credits <= out_credits;
      endcase

      out_valid <= send;
    end
  end

  // Every send frees one entry, so the credit return shares its cycle
  assign in_credit = out_valid;

endmodule

// ==== rtl/kd_tree_level.sv ====
/* One pipeline stage holding every node of a single tree level.
   Picks each lane's node by its path, appends the turn and registers the link. */

`timescale 1ns/10ps

module kd_tree_level #(
  parameter int level = 0 // 0 is the root level
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  cfg_wen,
  input  logic [kd_tree_pkg::node_addr_width-1:0] cfg_waddr,
  input  logic [kd_tree_pkg::cfg_width-1:0]     cfg_wdata,
  traverse_if.dst                               up,   // From previous level
  traverse_if.src                               down, // To next level
  output logic [(1 << level)-1:0][kd_tree_pkg::cfg_width-1:0] node_rdata
);
  import kd_tree_pkg::*;

  localparam int num_level_nodes = 1 << level;         // Nodes on this level
  localparam int first_node      = num_level_nodes - 1; // Heap index of leftmost node
  localparam int sel_width       = (level > 0) ? level : 1;

  logic [num_level_nodes-1:0] node_wen; // One write strobe per node
  logic [num_level_nodes-1:0] right_a;  // Every node's verdict for lane A
  logic [num_level_nodes-1:0] right_b;
  logic [sel_width-1:0]       sel_a;    // Node index of lane A within this level
  logic [sel_width-1:0]       sel_b;
  logic                       turn_a;   // Decision of the node on lane A's path
  logic                       turn_b;

  for (genvar i = 0; i < num_level_nodes; i++) begin : gen_node
    // Node i of this level owns heap address first_node + i
    assign node_wen[i] = cfg_wen && (cfg_waddr == node_addr_width'(first_node + i));

    internal_node u_node (
      .clk        (clk),
      .rst_n      (rst_n),
      .wen        (node_wen[i]),
      .wdata      (cfg_wdata),
      .patch_a    (up.patch_a),
      .patch_b    (up.patch_b),
      .go_right_a (right_a[i]),
      .go_right_b (right_b[i]),
      .rdata      (node_rdata[i])
    );
  end

  // The path so far is the node's index within this level
  // At the root it is all zero, so node 0 is picked
  assign sel_a = up.path_a[sel_width-1:0];
  assign sel_b = up.path_b[sel_width-1:0];

  assign turn_a = right_a[sel_a];
  assign turn_b = right_b[sel_b];

  // Lane valids are control, cleared on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      down.valid_a <= 1'b0;
      down.valid_b <= 1'b0;
    end else begin
      down.valid_a <= up.valid_a;
      down.valid_b <= up.valid_b;
    end
  end

  // Payload stage
  always_ff @(posedge clk) begin
    down.patch_a <= up.patch_a;
    down.patch_b <= up.patch_b;
    // Append this level's turn; an idle lane carries a zero path
    down.path_a  <= up.valid_a ? {up.path_a[leaf_width-2:0], turn_a} : '0;
    down.path_b  <= up.valid_b ? {up.path_b[leaf_width-2:0], turn_b} : '0;
  end

endmodule

// ==== rtl/internal_node.sv ====
/* One KD-tree node holding a split dimension and a median.
   Routes both lanes combinationally; a level instantiates one per node. */

`timescale 1ns/10ps

module internal_node (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wen,        // Decoded write for this node
  input  logic [kd_tree_pkg::cfg_width-1:0] wdata,
  input  kd_tree_pkg::patch_t            patch_a,
  input  kd_tree_pkg::patch_t            patch_b,
  output logic                           go_right_a, // Lane A turns right
  output logic                           go_right_b, // Lane B turns right
  output logic [kd_tree_pkg::cfg_width-1:0] rdata    // Node word for readback
);
  import kd_tree_pkg::*;

  localparam int pad_width = cfg_width - coord_width - dim_width; // 8 zero bits

  logic [dim_width-1:0]          dim;    // Split dimension
  logic signed [coord_width-1:0] median; // Split value
  logic signed [coord_width-1:0] coord_a;
  logic signed [coord_width-1:0] coord_b;

  // Slice coordinate d out of a patch, 0 for any index past the last dimension
  function automatic logic signed [coord_width-1:0] pick_coord(
    input patch_t                p,
    input logic [dim_width-1:0]  d
  );
    logic signed [coord_width-1:0] c;
    c = '0;
    for (int k = 0; k < num_dims; k++) begin
      if (d == dim_width'(k)) begin
        c = p[k*coord_width +: coord_width];
      end
    end
    return c;
  endfunction

  // Node storage, written in one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dim    <= dim_unloaded; // Reads back as 7 until loaded
      median <= '0;
    end else if (wen) begin
      dim    <= wdata[dim_width-1:0];
      median <= wdata[cfg_width-1 -: coord_width];
    end
  end

  assign coord_a = pick_coord(patch_a, dim);
  assign coord_b = pick_coord(patch_b, dim);

  // Signed compare, a tie goes right
  assign go_right_a = (coord_a >= median);
  assign go_right_b = (coord_b >= median);

  assign rdata = {median, {pad_width{1'b0}}, dim}; // Same packing as the write word

endmodule

// ==== rtl/traverse_if.sv ====
/* Link between two tree levels carrying both lanes' patches, valids and paths.
   A level drives it through src and the next level reads it through dst. */

`timescale 1ns/10ps

interface traverse_if;
  import kd_tree_pkg::*;

  patch_t                patch_a; // Lane A patch
  patch_t                patch_b; // Lane B patch
  logic                  valid_a; // Plain qualifier, no stall on this link
  logic                  valid_b;
  logic [leaf_width-1:0] path_a;  // Turns taken so far, newest bit in LSB
  logic [leaf_width-1:0] path_b;

  // Driving level
  modport src (
    output patch_a, patch_b,
    output valid_a, valid_b,
    output path_a,  path_b
  );

  // Receiving level
  modport dst (
    input patch_a, patch_b,
    input valid_a, valid_b,
    input path_a,  path_b
  );

endinterface

// ==== rtl/kd_tree_pkg.sv ====
/* Shared geometry, tree size and result types for the KD-tree search engine.
   Design files pull these in by wildcard import inside the module body. */

package kd_tree_pkg;

  // Patch geometry
  localparam int coord_width = 11; // One signed coordinate
  localparam int num_dims    = 5;  // Coordinates per patch
  localparam int patch_width = coord_width * num_dims; // 55 bits

  // Split dimension index, 7 marks a node that was never loaded
  localparam int dim_width = 3;
  localparam logic [dim_width-1:0] dim_unloaded = '1;

  // Tree shape, heap numbered: root 0, children of n at 2n+1 and 2n+2
  localparam int tree_depth      = 3; // Internal levels
  localparam int num_nodes       = (1 << tree_depth) - 1; // 7 internal nodes
  localparam int node_addr_width = 3;

  // Node word as seen on the config port
  // Median in the top 11 bits, dimension in the low 3, zeros between
  localparam int cfg_width = 22;

  localparam int leaf_width = tree_depth; // One path bit per level

  // Result buffer and credit accounting
  localparam int buf_depth    = 8; // Entries, also upstream credits after reset
  localparam int credit_width = 4; // Holds 0..buf_depth

  // Coordinate 0 sits in the least significant bits
  typedef logic [patch_width-1:0] patch_t;

  // One buffered result covers both lanes of a request
  typedef struct packed {
    logic [leaf_width-1:0] leaf_a; // Leaf reached by lane A
    logic [leaf_width-1:0] leaf_b; // Leaf reached by lane B
    logic                  hit_a;  // Lane A carried a patch
    logic                  hit_b;  // Lane B carried a patch
  } leaf_result_t;

endpackage
